// File: design/core_types_pkg.sv
/* Core-wide type definitions
   Datapath width and ROB tag shared by the station and its neighbours */

package core_types_pkg;

  // ------------------------------
  // Datapath
  // ------------------------------

  localparam int unsigned XLEN = 32;  // Operand and result width

  // ------------------------------
  // Reorder buffer
  // ------------------------------

  localparam int unsigned ROB_IDX_W = 4;  // 16 in-flight instructions

  // Tag of a ROB entry, names both producers and consumers
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

endpackage

// File: design/rs_pkg.sv
/* Reservation station definitions
   Entry states and the per-entry write operations on the entry buffer */

package rs_pkg;

  // Entry state
  typedef enum logic [2:0] {
    EMPTY,         // Free for a new instruction
    RS1_PENDING,   // Waiting for rs1
    RS2_PENDING,   // Waiting for rs2
    RS12_PENDING,  // Waiting for both operands
    EX_REQ,        // Requesting the EU
    EX_WAIT,       // Running on the EU
    COMPLETED      // Result ready for the CDB
  } rs_state_e;

  // Buffer write operation, one per entry and cycle
  typedef enum logic [3:0] {
    NONE,
    INSERT,       // Issue data as given
    INSERT_RS1,   // Issue data, rs1 from the EU result
    INSERT_RS2,   // Issue data, rs2 from the EU result
    INSERT_RS12,  // Issue data, both from the EU result
    SAVE_RS1,
    SAVE_RS2,
    SAVE_RS12,
    SAVE_RES      // Result from the EU
  } rs_op_e;

endpackage

// File: design/rs_wakeup.sv
/* Operand wakeup
   Matches EU and CDB result tags against issue and stored tags */

`timescale 1ns/1ns

module rs_wakeup import core_types_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  rob_idx_t             issue_rs1_tag_i,
  input  rob_idx_t             issue_rs2_tag_i,
  input  rob_idx_t [DEPTH-1:0] rs1_tag_i,
  input  rob_idx_t [DEPTH-1:0] rs2_tag_i,
  input  rob_idx_t [DEPTH-1:0] dest_tag_i,
  input  logic                 eu_result_valid_i,
  input  rob_idx_t             eu_result_tag_i,
  input  logic                 cdb_valid_i,
  input  rob_idx_t             cdb_tag_i,
  output logic                 ins_fwd_rs1_o,
  output logic                 ins_fwd_rs2_o,
  output logic [DEPTH-1:0]     fwd_rs1_o,
  output logic [DEPTH-1:0]     fwd_rs2_o,
  output logic [DEPTH-1:0]     fwd_rs1_eu_o,
  output logic [DEPTH-1:0]     fwd_rs2_eu_o,
  output logic [DEPTH-1:0]     res_match_o
);

  // Forwarding in the issue cycle, EU result only
  assign ins_fwd_rs1_o = eu_result_valid_i & (eu_result_tag_i == issue_rs1_tag_i);
  assign ins_fwd_rs2_o = eu_result_valid_i & (eu_result_tag_i == issue_rs2_tag_i);

  always_comb begin : p_match
    for (int i = 0; i < DEPTH; i++) begin
      fwd_rs1_eu_o[i] = eu_result_valid_i & (eu_result_tag_i == rs1_tag_i[i]);
      fwd_rs2_eu_o[i] = eu_result_valid_i & (eu_result_tag_i == rs2_tag_i[i]);
      fwd_rs1_o[i]    = fwd_rs1_eu_o[i] | (cdb_valid_i & (cdb_tag_i == rs1_tag_i[i]));
      fwd_rs2_o[i]    = fwd_rs2_eu_o[i] | (cdb_valid_i & (cdb_tag_i == rs2_tag_i[i]));
      res_match_o[i]  = eu_result_valid_i & (eu_result_tag_i == dest_tag_i[i]);
    end
  end

endmodule

// File: design/rs_entry_ctrl.sv
/* Entry control
   One FSM per entry; picks the buffer operation on each transition */

`timescale 1ns/1ns

module rs_entry_ctrl import rs_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     issue_valid_i,
  input  logic                     issue_ready_i,
  input  logic                     issue_rs1_ready_i,
  input  logic                     issue_rs2_ready_i,
  input  logic [$clog2(DEPTH)-1:0] new_idx_i,
  input  logic [$clog2(DEPTH)-1:0] ex_idx_i,
  input  logic [$clog2(DEPTH)-1:0] cdb_idx_i,
  input  logic                     eu_valid_i,
  input  logic                     eu_ready_i,
  input  logic                     cdb_valid_i,
  input  logic                     cdb_ready_i,
  input  logic                     ins_fwd_rs1_i,
  input  logic                     ins_fwd_rs2_i,
  input  logic [DEPTH-1:0]         fwd_rs1_i,
  input  logic [DEPTH-1:0]         fwd_rs2_i,
  input  logic [DEPTH-1:0]         res_match_i,
  output rs_op_e [DEPTH-1:0]       op_o,
  output logic [DEPTH-1:0]         empty_o,
  output logic [DEPTH-1:0]         ready_ex_o,
  output logic [DEPTH-1:0]         ready_cdb_o
);

  localparam int unsigned IDX_W = $clog2(DEPTH);

  rs_state_e [DEPTH-1:0] state_q, state_d;
  logic                  insert, accept, remove;
  logic                  fwd1, fwd2;
  rs_state_e             ins_state;
  rs_op_e                ins_op;
  logic [DEPTH-1:0]      save_res;

  // ------------------------------
  // Events
  // ------------------------------
  assign insert = issue_valid_i & issue_ready_i;
  assign accept = eu_valid_i & eu_ready_i;
  assign remove = cdb_valid_i & cdb_ready_i;

  // Operands caught from the EU in the issue cycle
  assign fwd1 = ~issue_rs1_ready_i & ins_fwd_rs1_i;
  assign fwd2 = ~issue_rs2_ready_i & ins_fwd_rs2_i;

  always_comb begin : p_insert
    if (fwd1 && fwd2) ins_op = INSERT_RS12;
    else if (fwd1) ins_op = INSERT_RS1;
    else if (fwd2) ins_op = INSERT_RS2;
    else ins_op = INSERT;

    if ((issue_rs1_ready_i | fwd1) && (issue_rs2_ready_i | fwd2)) ins_state = EX_REQ;
    else if (issue_rs1_ready_i | fwd1) ins_state = RS2_PENDING;
    else if (issue_rs2_ready_i | fwd2) ins_state = RS1_PENDING;
    else ins_state = RS12_PENDING;
  end

  // ------------------------------
  // Per-entry transitions
  // ------------------------------
  always_comb begin : p_next
    for (int i = 0; i < DEPTH; i++) begin
      state_d[i] = state_q[i];
      op_o[i]    = NONE;
      case (state_q[i])
        EMPTY: begin
          if (insert && new_idx_i == IDX_W'(i)) begin
            state_d[i] = ins_state;
            op_o[i]    = ins_op;
          end
        end
        RS12_PENDING: begin
          if (fwd_rs1_i[i] && fwd_rs2_i[i]) begin
            state_d[i] = EX_REQ;
            op_o[i]    = SAVE_RS12;
          end else if (fwd_rs1_i[i]) begin
            state_d[i] = RS2_PENDING;
            op_o[i]    = SAVE_RS1;
          end else if (fwd_rs2_i[i]) begin
            state_d[i] = RS1_PENDING;
            op_o[i]    = SAVE_RS2;
          end
        end
        RS1_PENDING: begin
          if (fwd_rs1_i[i]) begin
            state_d[i] = EX_REQ;
            op_o[i]    = SAVE_RS1;
          end
        end
        RS2_PENDING: begin
          if (fwd_rs2_i[i]) begin
            state_d[i] = EX_REQ;
            op_o[i]    = SAVE_RS2;
          end
        end
        EX_REQ, EX_WAIT: begin
          if (res_match_i[i]) begin  // Result back from the EU
            state_d[i] = COMPLETED;
            op_o[i]    = SAVE_RES;
          end else if (state_q[i] == EX_REQ && accept && ex_idx_i == IDX_W'(i)) begin
            state_d[i] = EX_WAIT;
          end
        end
        COMPLETED: begin
          if (remove && cdb_idx_i == IDX_W'(i)) state_d[i] = EMPTY;
        end
        default: state_d[i] = EMPTY;
      endcase
      save_res[i] = (op_o[i] == SAVE_RES);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= {DEPTH{EMPTY}};
    end else if (flush_i) begin
      state_q <= {DEPTH{EMPTY}};
    end else begin
      state_q <= state_d;
    end
  end

  // Status for the selectors
  always_comb begin : p_status
    for (int i = 0; i < DEPTH; i++) begin
      empty_o[i]     = (state_q[i] == EMPTY);
      ready_ex_o[i]  = (state_q[i] == EX_REQ);
      ready_cdb_o[i] = (state_q[i] == COMPLETED);
    end
  end

  // Free-entry encoder and issue handshake must agree with the FSMs
  a_insert_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insert |-> state_q[new_idx_i] == EMPTY)
    else $error("Insert into a busy entry");

  // Serial EU returns one tagged result at a time
  a_one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(save_res))
    else $error("Result captured by more than one entry");

endmodule

// File: design/rs_entry_buffer.sv
/* Entry buffer
   Per-entry operands, tags and result, written by the entry operations */

`timescale 1ns/1ns

module rs_entry_buffer import core_types_pkg::*, rs_pkg::*; #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned CTL_W = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rs_op_e [DEPTH-1:0]       op_i,
  input  logic [DEPTH-1:0]         fwd_rs1_eu_i,
  input  logic [DEPTH-1:0]         fwd_rs2_eu_i,
  input  logic [CTL_W-1:0]         issue_ctl_i,
  input  rob_idx_t                 issue_rs1_tag_i,
  input  logic [XLEN-1:0]          issue_rs1_value_i,
  input  rob_idx_t                 issue_rs2_tag_i,
  input  logic [XLEN-1:0]          issue_rs2_value_i,
  input  rob_idx_t                 issue_dest_tag_i,
  input  logic [XLEN-1:0]          eu_result_i,
  input  logic [XLEN-1:0]          cdb_value_i,
  input  logic [$clog2(DEPTH)-1:0] hold_idx_i,
  input  logic [$clog2(DEPTH)-1:0] cdb_idx_i,
  output rob_idx_t [DEPTH-1:0]     rs1_tag_o,
  output rob_idx_t [DEPTH-1:0]     rs2_tag_o,
  output rob_idx_t [DEPTH-1:0]     dest_tag_o,
  output logic [CTL_W-1:0]         eu_ctl_o,
  output logic [XLEN-1:0]          eu_rs1_o,
  output logic [XLEN-1:0]          eu_rs2_o,
  output rob_idx_t                 eu_tag_o,
  output rob_idx_t                 cdb_tag_o,
  output logic [XLEN-1:0]          cdb_value_o
);

  rob_idx_t [DEPTH-1:0] rs1_tag_q, rs2_tag_q, dest_tag_q;
  logic [CTL_W-1:0]     ctl_q  [DEPTH];
  logic [XLEN-1:0]      rs1_q  [DEPTH];
  logic [XLEN-1:0]      rs2_q  [DEPTH];
  logic [XLEN-1:0]      res_q  [DEPTH];

  // ------------------------------
  // Tags
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_tags
    if (!rst_ni) begin
      rs1_tag_q  <= '0;
      rs2_tag_q  <= '0;
      dest_tag_q <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (op_i[i] inside {INSERT, INSERT_RS1, INSERT_RS2, INSERT_RS12}) begin
          rs1_tag_q[i]  <= issue_rs1_tag_i;
          rs2_tag_q[i]  <= issue_rs2_tag_i;
          dest_tag_q[i] <= issue_dest_tag_i;
        end
      end
    end
  end

  // ------------------------------
  // Control, operands and result
  // ------------------------------
  always_ff @(posedge clk_i) begin : p_data
    for (int i = 0; i < DEPTH; i++) begin
      case (op_i[i])
        INSERT, INSERT_RS1, INSERT_RS2, INSERT_RS12: begin
          ctl_q[i] <= issue_ctl_i;
          rs1_q[i] <= (op_i[i] inside {INSERT_RS1, INSERT_RS12}) ? eu_result_i
                                                                 : issue_rs1_value_i;
          rs2_q[i] <= (op_i[i] inside {INSERT_RS2, INSERT_RS12}) ? eu_result_i
                                                                 : issue_rs2_value_i;
        end
        SAVE_RS1: rs1_q[i] <= fwd_rs1_eu_i[i] ? eu_result_i : cdb_value_i;
        SAVE_RS2: rs2_q[i] <= fwd_rs2_eu_i[i] ? eu_result_i : cdb_value_i;
        SAVE_RS12: begin  // Sources may differ per operand
          rs1_q[i] <= fwd_rs1_eu_i[i] ? eu_result_i : cdb_value_i;
          rs2_q[i] <= fwd_rs2_eu_i[i] ? eu_result_i : cdb_value_i;
        end
        SAVE_RES: res_q[i] <= eu_result_i;
        default: ;
      endcase
    end
  end

  assign rs1_tag_o  = rs1_tag_q;
  assign rs2_tag_o  = rs2_tag_q;
  assign dest_tag_o = dest_tag_q;

  // Dispatch port, stable while the EU works
  assign eu_ctl_o = ctl_q[hold_idx_i];
  assign eu_rs1_o = rs1_q[hold_idx_i];
  assign eu_rs2_o = rs2_q[hold_idx_i];
  assign eu_tag_o = dest_tag_q[hold_idx_i];

  // Broadcast port
  assign cdb_tag_o   = dest_tag_q[cdb_idx_i];
  assign cdb_value_o = res_q[cdb_idx_i];

endmodule

// File: design/rs_select.sv
/* Entry selection
   Lowest-index pick of free, dispatch and broadcast entries and the dispatch index hold */

`timescale 1ns/1ns

module rs_select #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic [DEPTH-1:0]         empty_i,
  input  logic [DEPTH-1:0]         ready_ex_i,
  input  logic [DEPTH-1:0]         ready_cdb_i,
  input  logic                     eu_ready_i,
  output logic [$clog2(DEPTH)-1:0] new_idx_o,
  output logic [$clog2(DEPTH)-1:0] ex_idx_o,
  output logic [$clog2(DEPTH)-1:0] cdb_idx_o,
  output logic [$clog2(DEPTH)-1:0] hold_idx_o,
  output logic                     issue_ready_o,
  output logic                     eu_valid_o,
  output logic                     cdb_valid_o
);

  localparam int unsigned IDX_W = $clog2(DEPTH);

  // Fixed priority with entry 0 first
  function automatic logic [IDX_W-1:0] lowest_idx(input logic [DEPTH-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (vec[i]) idx = IDX_W'(i);
    end
    return idx;
  endfunction

  assign new_idx_o = lowest_idx(empty_i);
  assign ex_idx_o  = lowest_idx(ready_ex_i);
  assign cdb_idx_o = lowest_idx(ready_cdb_i);

  assign issue_ready_o = |empty_i;
  assign eu_valid_o    = |ready_ex_i;
  assign cdb_valid_o   = |ready_cdb_i;

  // Dispatched entry kept until the next acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_hold
    if (!rst_ni) begin
      hold_idx_o <= '0;
    end else if (flush_i) begin
      hold_idx_o <= '0;
    end else if (eu_valid_o && eu_ready_i) begin
      hold_idx_o <= ex_idx_o;
    end
  end

  // Dispatch pick is a ready entry with no ready entry below it
  a_ex_pick: assert property (@(posedge clk_i) disable iff (!rst_ni)
    eu_valid_o |-> ready_ex_i[ex_idx_o] &&
                   (ready_ex_i & ((DEPTH'(1) << ex_idx_o) - 1'b1)) == '0)
    else $error("Dispatch pick is not the lowest ready entry");

endmodule

// File: design/rs_serial_top.sv
/* Reservation station for a serial execution unit
   Holds issued instructions until operands arrive, feeds the EU one at a time
   and broadcasts completed results on the CDB */

`timescale 1ns/1ns

module rs_serial_top import core_types_pkg::*, rs_pkg::*; #(
  parameter int unsigned DEPTH = 4,  // Power of two
  parameter int unsigned CTL_W = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,

  // Issue
  input  logic             issue_valid_i,
  output logic             issue_ready_o,
  input  logic [CTL_W-1:0] issue_ctl_i,
  input  logic             issue_rs1_ready_i,
  input  rob_idx_t         issue_rs1_tag_i,
  input  logic [XLEN-1:0]  issue_rs1_value_i,
  input  logic             issue_rs2_ready_i,
  input  rob_idx_t         issue_rs2_tag_i,
  input  logic [XLEN-1:0]  issue_rs2_value_i,
  input  rob_idx_t         issue_dest_tag_i,

  // Execution unit
  output logic             eu_valid_o,
  input  logic             eu_ready_i,
  output logic [CTL_W-1:0] eu_ctl_o,
  output logic [XLEN-1:0]  eu_rs1_o,
  output logic [XLEN-1:0]  eu_rs2_o,
  output rob_idx_t         eu_tag_o,
  input  logic             eu_result_valid_i,
  input  rob_idx_t         eu_result_tag_i,
  input  logic [XLEN-1:0]  eu_result_i,

  // CDB
  output logic             cdb_valid_o,
  input  logic             cdb_ready_i,
  output rob_idx_t         cdb_tag_o,
  output logic [XLEN-1:0]  cdb_value_o,
  input  logic             cdb_valid_i,  // Snoop port
  input  rob_idx_t         cdb_tag_i,
  input  logic [XLEN-1:0]  cdb_value_i
);

  localparam int unsigned IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0]      new_idx, ex_idx, cdb_idx, hold_idx;
  logic [DEPTH-1:0]      empty, ready_ex, ready_cdb;
  rs_op_e [DEPTH-1:0]    op;
  rob_idx_t [DEPTH-1:0]  rs1_tag, rs2_tag, dest_tag;
  logic                  ins_fwd_rs1, ins_fwd_rs2;
  logic [DEPTH-1:0]      fwd_rs1, fwd_rs2, fwd_rs1_eu, fwd_rs2_eu, res_match;

  rs_entry_ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk_i, .rst_ni, .flush_i, .issue_valid_i,
    .issue_ready_i     (issue_ready_o),
    .issue_rs1_ready_i, .issue_rs2_ready_i,
    .new_idx_i         (new_idx),
    .ex_idx_i          (ex_idx),
    .cdb_idx_i         (cdb_idx),
    .eu_valid_i        (eu_valid_o),
    .eu_ready_i,
    .cdb_valid_i       (cdb_valid_o),  // Own broadcast
    .cdb_ready_i,
    .ins_fwd_rs1_i     (ins_fwd_rs1),
    .ins_fwd_rs2_i     (ins_fwd_rs2),
    .fwd_rs1_i         (fwd_rs1),
    .fwd_rs2_i         (fwd_rs2),
    .res_match_i       (res_match),
    .op_o              (op),
    .empty_o           (empty),
    .ready_ex_o        (ready_ex),
    .ready_cdb_o       (ready_cdb)
  );

  rs_wakeup #(.DEPTH(DEPTH)) u_wakeup (
    .issue_rs1_tag_i, .issue_rs2_tag_i,
    .rs1_tag_i         (rs1_tag),
    .rs2_tag_i         (rs2_tag),
    .dest_tag_i        (dest_tag),
    .eu_result_valid_i, .eu_result_tag_i, .cdb_valid_i, .cdb_tag_i,
    .ins_fwd_rs1_o     (ins_fwd_rs1),
    .ins_fwd_rs2_o     (ins_fwd_rs2),
    .fwd_rs1_o         (fwd_rs1),
    .fwd_rs2_o         (fwd_rs2),
    .fwd_rs1_eu_o      (fwd_rs1_eu),
    .fwd_rs2_eu_o      (fwd_rs2_eu),
    .res_match_o       (res_match)
  );

  rs_entry_buffer #(.DEPTH(DEPTH), .CTL_W(CTL_W)) u_buffer (
    .clk_i, .rst_ni,
    .op_i              (op),
    .fwd_rs1_eu_i      (fwd_rs1_eu),
    .fwd_rs2_eu_i      (fwd_rs2_eu),
    .issue_ctl_i, .issue_rs1_tag_i, .issue_rs1_value_i,
    .issue_rs2_tag_i, .issue_rs2_value_i, .issue_dest_tag_i,
    .eu_result_i, .cdb_value_i,
    .hold_idx_i        (hold_idx),
    .cdb_idx_i         (cdb_idx),
    .rs1_tag_o         (rs1_tag),
    .rs2_tag_o         (rs2_tag),
    .dest_tag_o        (dest_tag),
    .eu_ctl_o, .eu_rs1_o, .eu_rs2_o, .eu_tag_o, .cdb_tag_o, .cdb_value_o
  );

  rs_select #(.DEPTH(DEPTH)) u_select (
    .clk_i, .rst_ni, .flush_i,
    .empty_i           (empty),
    .ready_ex_i        (ready_ex),
    .ready_cdb_i       (ready_cdb),
    .eu_ready_i,
    .new_idx_o         (new_idx),
    .ex_idx_o          (ex_idx),
    .cdb_idx_o         (cdb_idx),
    .hold_idx_o        (hold_idx),
    .issue_ready_o, .eu_valid_o, .cdb_valid_o
  );

endmodule

// File: verification/tb_rs_model.svh
/* Reference model for the reservation station testbench
   Expected value per ROB tag, pending producers and outside producer tags */

`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

localparam int N_DEST   = 8;  // Tags 0..7 name issued instructions
localparam int EXT_BASE = 8;  // Tags 8..15 name producers outside the station
localparam int MAX_LAT  = 4;

logic [XLEN-1:0]  tag_val [16];  // Value each tag will carry
logic [XLEN-1:0]  exp_a   [16];  // Expected EU operands per destination tag
logic [XLEN-1:0]  exp_b   [16];
logic [CTL_W-1:0] exp_ctl [16];  // Expected EU control per destination tag
bit               in_flight [16];
bit               pend      [16];  // Result not yet returned by the EU
bit               ext_busy  [16];
int               ext_q [$];       // Outside values still to come over the snoop port
int               occ;
int               issued;
int               bcast;
int               flushed;

// EU function selected by the low two control bits
function automatic logic [XLEN-1:0] eu_func(input logic [CTL_W-1:0] ctl,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  case (ctl[1:0])
    2'd0:    return a + b;
    2'd1:    return a - b;
    2'd2:    return a ^ b;
    default: return a & b;
  endcase
endfunction

function automatic int rand_below(input int n);
  return ($random(seed) & 32'h7fff_ffff) % n;
endfunction

// Random free tag in [base, base+8)
function automatic int free_tag(input int base, input bit ext);
  int start;
  int t;
  start = rand_below(8);
  for (int k = 0; k < 8; k++) begin
    t = base + (start + k) % 8;
    if (ext ? !ext_busy[t] : !in_flight[t]) return t;
  end
  return -1;
endfunction

function automatic int pick_producer();
  int cand [$];
  for (int t = 0; t < N_DEST; t++) begin
    if (in_flight[t] && pend[t]) cand.push_back(t);
  end
  if (cand.size() == 0) return -1;
  return cand[rand_below(cand.size())];
endfunction

function automatic int pending_count();
  int n;
  n = 0;
  for (int t = 0; t < N_DEST; t++) begin
    if (in_flight[t] && pend[t]) n++;
  end
  return n;
endfunction

function automatic void model_flush();
  for (int t = 0; t < 16; t++) begin
    if (in_flight[t]) flushed++;
    in_flight[t] = 0;
    pend[t]      = 0;
    ext_busy[t]  = 0;
  end
  ext_q.delete();
  occ = 0;
endfunction

`endif

// File: verification/tb_rs_serial.sv
/* Reservation station testbench
   Random issue traffic, serial EU model and CDB checks against a reference model */

`timescale 1ns/1ns

module tb_rs_serial import core_types_pkg::*; ();

  localparam int DEPTH = 4;
  localparam int CTL_W = 4;
  localparam int N_TX  = 20 + 30 + DEPTH + DEPTH + 10 + 200;  // Issues over all tests

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush_i, issue_valid_i, issue_ready_o, issue_rs1_ready_i, issue_rs2_ready_i;
  logic [CTL_W-1:0] issue_ctl_i, eu_ctl_o;
  rob_idx_t issue_rs1_tag_i, issue_rs2_tag_i, issue_dest_tag_i;
  rob_idx_t eu_tag_o, eu_result_tag_i, cdb_tag_o, cdb_tag_i;
  logic [XLEN-1:0] issue_rs1_value_i, issue_rs2_value_i, eu_rs1_o, eu_rs2_o;
  logic [XLEN-1:0] eu_result_i, cdb_value_o, cdb_value_i;
  logic eu_valid_o, eu_ready_i, eu_result_valid_i, cdb_valid_o, cdb_ready_i, cdb_valid_i;

  integer seed = 32'h9747_f73d;
  int     errors = 0;
  int     p_issue = 0;      // Percent chances per cycle
  int     p_ext = 0;
  int     p_dep = 0;
  int     p_cdb_ready = 100;
  bit     en_eu = 1;
  bit     flush_req = 0;

  // Serial EU model state
  bit              eu_busy = 0;
  bit              eu_sample = 0;
  bit              eu_have_ops = 0;
  int              eu_cnt = 0;
  rob_idx_t        eu_tag = '0;
  logic [XLEN-1:0] eu_res = '0;

  `include "tb_rs_model.svh"

  always #50 clk_i = ~clk_i;

  rs_serial_top #(.DEPTH(DEPTH), .CTL_W(CTL_W)) DUT (.*);

  // ------------------------------
  // Stimulus and sampling
  // ------------------------------
  function automatic void pick_src(input bit res_v, output logic rdy, output rob_idx_t tag,
                                   output logic [XLEN-1:0] val);
    int r;
    int t;
    r   = rand_below(100);
    rdy = 1'b1;
    tag = '0;
    val = $random(seed);
    if (r < p_dep) begin
      t = (res_v && rand_below(2) == 0) ? int'(eu_tag) : pick_producer();
      if (t >= 0) begin
        rdy = 1'b0;
        tag = rob_idx_t'(t);
        val = tag_val[t];
      end
    end else if (r < p_dep + p_ext) begin
      t = free_tag(EXT_BASE, 1'b1);
      if (t >= 0) begin
        rdy         = 1'b0;
        tag         = rob_idx_t'(t);
        tag_val[t]  = val;
        ext_busy[t] = 1;
        ext_q.push_back(t);
      end
    end
  endfunction

  task automatic drive_inputs();
    bit              res_v;
    int              t_cdb;
    int              d;
    logic            r1;
    logic            r2;
    rob_idx_t        t1;
    rob_idx_t        t2;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [CTL_W-1:0] ctl;
    res_v = 0;
    t_cdb = -1;
    d     = -1;
    if (eu_have_ops) begin  // Latency countdown
      if (eu_cnt > 1) begin
        eu_cnt--;
      end else begin
        res_v       = 1;
        eu_have_ops = 0;
        eu_busy     = 0;
      end
    end
    eu_result_valid_i <= res_v;
    eu_result_tag_i   <= eu_tag;
    eu_result_i       <= eu_res;
    eu_ready_i        <= en_eu && !eu_busy && !flush_req && rand_below(2) == 0;
    if (ext_q.size() > 0 && rand_below(4) == 0) t_cdb = ext_q.pop_front();
    cdb_valid_i <= (t_cdb >= 0);
    cdb_tag_i   <= rob_idx_t'(t_cdb);
    cdb_value_i <= (t_cdb >= 0) ? tag_val[t_cdb] : '0;
    if (!flush_req && occ < DEPTH && rand_below(100) < p_issue) d = free_tag(0, 1'b0);
    if (d >= 0) begin
      ctl = CTL_W'($random(seed));
      pick_src(res_v, r1, t1, a);
      pick_src(res_v, r2, t2, b);
      tag_val[d]   = eu_func(ctl, a, b);
      exp_a[d]     = a;
      exp_b[d]     = b;
      exp_ctl[d]   = ctl;
      in_flight[d] = 1;
      pend[d]      = 1;
      occ++;
      issued++;
      issue_ctl_i       <= ctl;
      issue_rs1_ready_i <= r1;
      issue_rs1_tag_i   <= t1;
      issue_rs1_value_i <= r1 ? a : $random(seed);  // Ignored while pending
      issue_rs2_ready_i <= r2;
      issue_rs2_tag_i   <= t2;
      issue_rs2_value_i <= r2 ? b : $random(seed);
      issue_dest_tag_i  <= rob_idx_t'(d);
    end
    issue_valid_i <= (d >= 0);
    if (res_v) pend[eu_tag] = 0;
    if (t_cdb >= 0) ext_busy[t_cdb] = 0;
    cdb_ready_i <= !flush_req && rand_below(100) < p_cdb_ready;
    flush_i     <= flush_req;
    flush_req = 0;
  endtask

  task automatic sample_outputs();
    if (issue_valid_i && !issue_ready_o) begin
      $display("Issue refused although the station had a free entry");
      errors++;
    end
    if (eu_sample) begin  // Operands one cycle after acceptance
      if (!in_flight[eu_tag_o] || !pend[eu_tag_o]) begin
        $display("EU received tag %0d with no instruction waiting for it", eu_tag_o);
        errors++;
      end else begin
        if (eu_ctl_o !== exp_ctl[eu_tag_o]) begin
          $display("[FAIL] eu_ctl_o: got %h, expected %h", eu_ctl_o, exp_ctl[eu_tag_o]);
          errors++;
        end
        if (eu_rs1_o !== exp_a[eu_tag_o]) begin
          $display("[FAIL] eu_rs1_o: got %h, expected %h", eu_rs1_o, exp_a[eu_tag_o]);
          errors++;
        end
        if (eu_rs2_o !== exp_b[eu_tag_o]) begin
          $display("[FAIL] eu_rs2_o: got %h, expected %h", eu_rs2_o, exp_b[eu_tag_o]);
          errors++;
        end
      end
      eu_tag      = eu_tag_o;
      eu_res      = eu_func(eu_ctl_o, eu_rs1_o, eu_rs2_o);
      eu_cnt      = 1 + rand_below(MAX_LAT);
      eu_have_ops = 1;
      eu_sample   = 0;
    end
    if (eu_valid_o && eu_ready_i) begin
      eu_busy   = 1;
      eu_sample = 1;
    end
    if (cdb_valid_o && cdb_ready_i) begin
      if (!in_flight[cdb_tag_o]) begin
        $display("CDB broadcast of tag %0d, which is flushed or not in flight", cdb_tag_o);
        errors++;
      end else begin
        if (cdb_value_o !== tag_val[cdb_tag_o]) begin
          $display("[FAIL] cdb_value_o tag %h: got %h, expected %h", cdb_tag_o, cdb_value_o,
                   tag_val[cdb_tag_o]);
          errors++;
        end
        in_flight[cdb_tag_o] = 0;
        occ--;
        bcast++;
      end
    end
    if (flush_i) model_flush();
  endtask

  task automatic run_cycle();
    @(posedge clk_i);
    drive_inputs();
    @(negedge clk_i);
    sample_outputs();
  endtask

  task automatic issue_n(input int n);
    int target;
    target = issued + n;
    while (issued < target) run_cycle();
    p_issue = 0;
  endtask

  task automatic drain();
    p_issue = 0;
    en_eu   = 1;
    while (occ > 0 || ext_q.size() > 0 || eu_busy) run_cycle();
  endtask

  task automatic report(input string name, input int err0);
    $display("%-16s %s", name, (errors == err0) ? "passed" : "reported errors");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  initial begin : main
    int              err0;
    rob_idx_t        h_tag;
    logic [XLEN-1:0] h_val;
    {flush_i, issue_valid_i, issue_rs1_ready_i, issue_rs2_ready_i} <= '0;
    {issue_ctl_i, issue_rs1_tag_i, issue_rs2_tag_i, issue_dest_tag_i} <= '0;
    {issue_rs1_value_i, issue_rs2_value_i, eu_result_i, cdb_value_i} <= '0;
    {eu_ready_i, eu_result_valid_i, eu_result_tag_i, cdb_ready_i, cdb_valid_i, cdb_tag_i} <= '0;
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    err0 = errors;
    check_bit("issue_ready_o", issue_ready_o, 1'b1);
    check_bit("eu_valid_o", eu_valid_o, 1'b0);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
    report("reset", err0);

    err0 = errors;
    p_issue = 50;
    issue_n(20);
    drain();
    report("ready_operands", err0);

    err0 = errors;
    p_ext = 40;
    p_dep = 40;
    p_issue = 40;
    issue_n(30);
    drain();
    report("pending_operands", err0);

    err0 = errors;
    p_ext = 0;
    p_dep = 0;
    p_cdb_ready = 0;
    p_issue = 100;
    issue_n(DEPTH);
    while (pending_count() > 0 || eu_busy) run_cycle();
    run_cycle();
    run_cycle();
    check_bit("issue_ready_o", issue_ready_o, 1'b0);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b1);
    h_tag = cdb_tag_o;
    h_val = cdb_value_o;
    repeat (4) begin
      run_cycle();
      if (cdb_tag_o !== h_tag || cdb_value_o !== h_val) begin
        $display("[FAIL] cdb_tag_o/cdb_value_o: got %h/%h, held %h/%h", cdb_tag_o, cdb_value_o,
                 h_tag, h_val);
        errors++;
      end
    end
    p_cdb_ready = 100;
    drain();
    report("full_station", err0);

    err0 = errors;
    p_ext = 60;
    p_dep = 20;
    p_cdb_ready = 0;
    p_issue = 100;
    issue_n(DEPTH);
    repeat (3) run_cycle();
    en_eu = 0;
    while (eu_busy) run_cycle();
    flush_req = 1;
    run_cycle();
    run_cycle();
    check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
    check_bit("eu_valid_o", eu_valid_o, 1'b0);
    check_bit("issue_ready_o", issue_ready_o, 1'b1);
    en_eu = 1;
    p_cdb_ready = 50;
    p_ext = 30;
    p_dep = 30;
    p_issue = 50;
    issue_n(10);
    drain();
    report("flush", err0);

    err0 = errors;
    p_issue = 60;
    issue_n(200);
    drain();
    report("random_mix", err0);

    $display("Summary: %0d issued, %0d broadcast, %0d flushed, %0d errors", issued, bcast,
             flushed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Generous bound of 30 cycles per issued instruction
  initial begin : watchdog
    #(N_TX * 30 * 100);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+verification
design/core_types_pkg.sv
design/rs_pkg.sv
design/rs_wakeup.sv
design/rs_entry_ctrl.sv
design/rs_entry_buffer.sv
design/rs_select.sv
design/rs_serial_top.sv
verification/tb_rs_serial.sv

// File: run.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Wno-fatal --top-module tb_rs_serial \
  -f src.f -o tb_rs_serial
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_rs_serial)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
